//--- flist.f
rtl/ooo_pkg.sv
rtl/inst_decoder.sv
rtl/map_table.sv
rtl/dispatcher.sv
rtl/alu_station.sv
rtl/reorder_buffer.sv
rtl/register_file.sv
rtl/ooo_core_top.sv
tb/tb_ooo_core.sv

//--- run.sh
#!/bin/sh
# compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ooo_core -Mdir obj_dir -o sim_tb \
    -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0

//--- tb/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int STALL_LIMIT = 100;
    localparam int DRAIN_LIMIT = 300;

    logic      clk;
    logic      reset;
    logic      inst_valid;
    word_t     inst_word;
    logic      stall;
    logic      commit_valid;
    reg_addr_t commit_reg;
    word_t     commit_data;

    // in-order reference state and the commits still owed by the DUT
    word_t     gold [REG_NUM];
    reg_addr_t exp_reg_q [$];
    word_t     exp_val_q [$];

    int        fail_count;
    logic      stall_seen;

    ooo_core_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_word    (inst_word),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s (time %0t)", why, $time);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            fail_count++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "run stopped");
        end
    endtask

    function automatic word_t rr_word(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t ri_word(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // executes one word on the reference state and queues its commit
    task automatic push_expected(input word_t w);
        logic [6:0] opc;
        logic [2:0] f3;
        logic       alt;
        logic [4:0] sh;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      res;
        opc = w[6:0];
        f3  = w[14:12];
        alt = w[30];
        rd  = w[11:7];
        res = '0;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            a  = gold[w[19:15]];
            b  = (opc == OPC_OP) ? gold[w[24:20]] : {{20{w[31]}}, w[31:20]};
            sh = b[4:0];
            case (f3)
                3'd0: res = (opc == OPC_OP && alt) ? a - b : a + b;
                3'd1: res = a << sh;
                3'd2: res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
                3'd3: res = {31'b0, a < b};
                3'd4: res = a ^ b;
                3'd5: res = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
                3'd6: res = a | b;
                default: res = a & b;
            endcase
            if (rd != 5'd0) begin
                gold[rd] = res;
            end
        end else begin
            // anything else retires as x0 with a zero value
            rd = 5'd0;
        end
        exp_reg_q.push_back(rd);
        exp_val_q.push_back(res);
    endtask

    // holds the word until an edge with stall low takes it
    task automatic send(input word_t w);
        int waited;
        push_expected(w);
        inst_valid = 1'b1;
        inst_word  = w;
        waited     = 0;
        @(negedge clk);
        while (stall) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                abort_run("stall stayed high and the instruction was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (exp_reg_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("commits stopped arriving before all instructions retired");
            end
            @(posedge clk);
        end
        #1;
    endtask

    function automatic word_t random_inst();
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  shamt;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        f3    = 3'($urandom_range(7, 0));
        rd    = reg_addr_t'($urandom_range(7, 0));
        rs1   = reg_addr_t'($urandom_range(7, 0));
        rs2   = reg_addr_t'($urandom_range(7, 0));
        shamt = 5'($urandom_range(31, 0));
        alt   = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom_range(1, 0)) : 1'b0;
        if ($urandom_range(1, 0) == 0) begin
            return rr_word({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        end
        if (f3 == 3'd1) begin
            imm = {7'b0, shamt};
        end else if (f3 == 3'd5) begin
            imm = {1'b0, alt, 5'b0, shamt};
        end else begin
            imm = 12'($urandom);
        end
        return ri_word(imm, rs1, f3, rd);
    endfunction

    task automatic after_reset();
        check_value(word_t'(commit_valid), 32'd0, "commit_valid after reset");
        check_value(word_t'(stall), 32'd0, "stall after reset");
        // every register read back through an add with x0
        for (int k = 1; k < REG_NUM; k++) begin
            send(rr_word(7'h00, 5'd0, reg_addr_t'(k), 3'd0, reg_addr_t'(k)));
        end
        drain();
    endtask

    task automatic each_alu_op();
        logic [11:0] imm;
        send(ri_word(12'hfec, 5'd0, 3'd0, 5'd1));
        send(ri_word(12'd7, 5'd0, 3'd0, 5'd2));
        send(ri_word(12'h5a3, 5'd0, 3'd0, 5'd3));
        for (int f3 = 0; f3 < 8; f3++) begin
            send(rr_word(7'h00, 5'd2, 5'd1, 3'(f3), reg_addr_t'(10 + f3)));
            send(rr_word(7'h00, 5'd1, 5'd2, 3'(f3), reg_addr_t'(18 + f3)));
        end
        send(rr_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd26));
        send(rr_word(7'h20, 5'd2, 5'd1, 3'd5, 5'd27));
        send(rr_word(7'h20, 5'd1, 5'd3, 3'd0, 5'd28));
        for (int f3 = 0; f3 < 8; f3++) begin
            imm = (f3 == 1 || f3 == 5) ? 12'd6 : 12'h9c4;
            send(ri_word(imm, 5'd1, 3'(f3), reg_addr_t'(10 + f3)));
            imm = (f3 == 1 || f3 == 5) ? 12'd17 : 12'h0ff;
            send(ri_word(imm, 5'd3, 3'(f3), reg_addr_t'(18 + f3)));
        end
        // srai on a negative value
        send(ri_word(12'h405, 5'd1, 3'd5, 5'd29));
        drain();
    endtask

    task automatic raw_chains();
        repeat (6) begin
            send(ri_word(12'd3, 5'd4, 3'd0, 5'd4));
        end
        send(rr_word(7'h00, 5'd1, 5'd4, 3'd4, 5'd5));
        send(rr_word(7'h00, 5'd5, 5'd5, 3'd0, 5'd5));
        // gaps of 0..3 move the consumer from pending to CDB, ROB and regfile
        for (int g = 0; g < 4; g++) begin
            send(ri_word(12'(100 + g), 5'd0, 3'd0, 5'd6));
            repeat (g) begin
                send(ri_word(12'(g), 5'd0, 3'd0, 5'd7));
            end
            send(rr_word(7'h00, 5'd6, 5'd6, 3'd0, 5'd8));
            send(rr_word(7'h20, 5'd6, 5'd8, 3'd0, 5'd9));
        end
        drain();
    endtask

    task automatic back_pressure();
        stall_seen = 1'b0;
        // chained adds retire slower than they arrive so the station fills
        for (int k = 1; k <= 12; k++) begin
            send(ri_word(12'(k), reg_addr_t'(k - 1), 3'd0, reg_addr_t'(k)));
        end
        drain();
        if (!stall_seen) begin
            abort_run("stall never rose while the burst filled the station");
        end
        for (int k = 1; k <= 12; k++) begin
            send(ri_word(12'(k * 5), 5'd0, 3'd0, reg_addr_t'(12 + k)));
        end
        drain();
    endtask

    task automatic x0_and_unsupported();
        send(ri_word(12'd55, 5'd0, 3'd0, 5'd0));
        send(rr_word(7'h00, 5'd1, 5'd2, 3'd0, 5'd0));
        send(rr_word(7'h00, 5'd0, 5'd0, 3'd6, 5'd9));
        // branch, load, all-ones and jal words
        send(32'h0000_0063);
        send(32'h0000_2003);
        send(32'hffff_ffff);
        send(32'h0000_006f);
        send(ri_word(12'd1, 5'd0, 3'd0, 5'd10));
        drain();
    endtask

    task automatic random_mix();
        for (int n = 0; n < 200; n++) begin
            send(random_inst());
        end
        drain();
    endtask

    // commit monitor
    always @(negedge clk) begin
        if (!reset) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            if (commit_valid) begin
                if (exp_reg_q.size() == 0) begin
                    abort_run("a commit arrived with no instruction outstanding");
                end else begin
                    check_value(word_t'(commit_reg), word_t'(exp_reg_q.pop_front()),
                                "commit_reg");
                    check_value(commit_data, exp_val_q.pop_front(), "commit_data");
                end
            end
        end
    end

    initial begin
        fail_count   = 0;
        stall_seen   = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_word    = '0;
        void'($urandom(40));
        for (int i = 0; i < REG_NUM; i++) begin
            gold[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        after_reset();
        each_alu_op();
        raw_chains();
        back_pressure();
        x0_and_unsupported();
        random_mix();

        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  ooo_pkg::word_t     inst_word,
    output logic               stall,
    output logic               commit_valid,
    output ooo_pkg::reg_addr_t commit_reg,
    output ooo_pkg::word_t     commit_data
);
    import ooo_pkg::*;

    // decoder outputs
    alu_op_e   dec_op;
    inst_fmt_e dec_fmt;
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    word_t     dec_imm;

    // held instruction sources and their rename state
    reg_addr_t src1_reg;
    reg_addr_t src2_reg;
    logic      src1_busy;
    logic      src2_busy;
    rob_tag_t  src1_tag;
    rob_tag_t  src2_tag;
    word_t     rf_data1;
    word_t     rf_data2;
    logic      rob_ready1;
    logic      rob_ready2;
    word_t     rob_data1;
    word_t     rob_data2;

    logic      rob_full;
    logic      rs_full;
    rob_tag_t  rob_tail;
    rob_tag_t  rob_head;
    rob_tag_t  commit_tag;

    // issue bus to station and ROB
    logic      issue;
    alu_op_e   issue_op;
    reg_addr_t issue_dest;
    rob_tag_t  issue_tag;
    word_t     issue_v1;
    word_t     issue_v2;
    logic      issue_r1;
    logic      issue_r2;
    rob_tag_t  issue_t1;
    rob_tag_t  issue_t2;

    logic      rename_valid;
    reg_addr_t rename_reg;
    rob_tag_t  rename_tag;

    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    word_t     cdb_data;

    inst_decoder decoder0 (
        .inst_word (inst_word),
        .op        (dec_op),
        .fmt       (dec_fmt),
        .rd        (dec_rd),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .imm       (dec_imm)
    );

    dispatcher dispatcher0 (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .op           (dec_op),
        .fmt          (dec_fmt),
        .rd           (dec_rd),
        .rs1          (dec_rs1),
        .rs2          (dec_rs2),
        .imm          (dec_imm),
        .src1_busy    (src1_busy),
        .src1_tag     (src1_tag),
        .src2_busy    (src2_busy),
        .src2_tag     (src2_tag),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .rob_ready1   (rob_ready1),
        .rob_data1    (rob_data1),
        .rob_ready2   (rob_ready2),
        .rob_data2    (rob_data2),
        .rob_full     (rob_full),
        .rob_tail     (rob_tail),
        .rs_full      (rs_full),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .src1_reg     (src1_reg),
        .src2_reg     (src2_reg),
        .stall        (stall),
        .issue        (issue),
        .issue_op     (issue_op),
        .issue_dest   (issue_dest),
        .issue_tag    (issue_tag),
        .issue_v1     (issue_v1),
        .issue_v2     (issue_v2),
        .issue_r1     (issue_r1),
        .issue_r2     (issue_r2),
        .issue_t1     (issue_t1),
        .issue_t2     (issue_t2),
        .rename_valid (rename_valid),
        .rename_reg   (rename_reg),
        .rename_tag   (rename_tag)
    );

    map_table map_table0 (
        .clk          (clk),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_reg   (rename_reg),
        .rename_tag   (rename_tag),
        .rs1          (src1_reg),
        .rs2          (src2_reg),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag),
        .src1_busy    (src1_busy),
        .src1_tag     (src1_tag),
        .src2_busy    (src2_busy),
        .src2_tag     (src2_tag)
    );

    alu_station alu_station0 (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .issue_op  (issue_op),
        .issue_tag (issue_tag),
        .issue_v1  (issue_v1),
        .issue_v2  (issue_v2),
        .issue_r1  (issue_r1),
        .issue_r2  (issue_r2),
        .issue_t1  (issue_t1),
        .issue_t2  (issue_t2),
        .rob_head  (rob_head),
        .rs_full   (rs_full),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data)
    );

    reorder_buffer rob0 (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .issue_dest   (issue_dest),
        .issue_tag    (issue_tag),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .rob_full     (rob_full),
        .rob_tail     (rob_tail),
        .rob_head     (rob_head),
        .rob_ready1   (rob_ready1),
        .rob_data1    (rob_data1),
        .rob_ready2   (rob_ready2),
        .rob_data2    (rob_data2),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag),
        .commit_data  (commit_data)
    );

    register_file regfile0 (
        .clk      (clk),
        .reset    (reset),
        .rs1      (src1_reg),
        .rs2      (src2_reg),
        .wr_valid (commit_valid),
        .wr_reg   (commit_reg),
        .wr_data  (commit_data),
        .rf_data1 (rf_data1),
        .rf_data2 (rf_data2)
    );

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  ooo_pkg::reg_addr_t rs1,
    input  ooo_pkg::reg_addr_t rs2,
    input  logic               wr_valid,
    input  ooo_pkg::reg_addr_t wr_reg,
    input  ooo_pkg::word_t     wr_data,
    output ooo_pkg::word_t     rf_data1,
    output ooo_pkg::word_t     rf_data2
);
    import ooo_pkg::*;

    word_t regs [REG_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid && wr_reg != '0) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // no write bypass, the map table still flags the register busy
    assign rf_data1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rf_data2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  ooo_pkg::reg_addr_t issue_dest,
    input  ooo_pkg::rob_tag_t  issue_tag,
    input  ooo_pkg::rob_tag_t  src1_tag,
    input  ooo_pkg::rob_tag_t  src2_tag,
    input  logic               cdb_valid,
    input  ooo_pkg::rob_tag_t  cdb_tag,
    input  ooo_pkg::word_t     cdb_data,
    output logic               rob_full,
    output ooo_pkg::rob_tag_t  rob_tail,
    output ooo_pkg::rob_tag_t  rob_head,
    output logic               rob_ready1,
    output ooo_pkg::word_t     rob_data1,
    output logic               rob_ready2,
    output ooo_pkg::word_t     rob_data2,
    output logic               commit_valid,
    output ooo_pkg::reg_addr_t commit_reg,
    output ooo_pkg::rob_tag_t  commit_tag,
    output ooo_pkg::word_t     commit_data
);
    import ooo_pkg::*;

    logic      ent_valid [ROB_SIZE];
    logic      ent_done  [ROB_SIZE];
    reg_addr_t ent_reg   [ROB_SIZE];
    word_t     ent_data  [ROB_SIZE];

    logic [$clog2(ROB_SIZE):0] count;

    assign commit_valid = ent_valid[rob_head] && ent_done[rob_head];
    assign commit_reg   = ent_reg[rob_head];
    assign commit_tag   = rob_head;
    assign commit_data  = ent_data[rob_head];

    // the head slot frees up this cycle when it commits
    assign rob_full = (count == ROB_SIZE) && !commit_valid;

    assign rob_ready1 = ent_valid[src1_tag] && ent_done[src1_tag];
    assign rob_data1  = ent_data[src1_tag];
    assign rob_ready2 = ent_valid[src2_tag] && ent_done[src2_tag];
    assign rob_data2  = ent_data[src2_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ROB_SIZE; i++) begin
                ent_valid[i] <= 1'b0;
                ent_done[i]  <= 1'b0;
            end
            rob_head <= '0;
            rob_tail <= '0;
            count    <= '0;
        end else begin
            if (commit_valid) begin
                ent_valid[rob_head] <= 1'b0;
                rob_head            <= rob_head + 3'd1;
            end
            if (cdb_valid) begin
                ent_done[cdb_tag] <= 1'b1;
            end
            // allocation after commit so a reused slot comes out valid
            if (issue) begin
                ent_valid[issue_tag] <= 1'b1;
                ent_done[issue_tag]  <= 1'b0;
                rob_tail             <= rob_tail + 3'd1;
            end
            if (issue && !commit_valid) begin
                count <= count + 1'b1;
            end else if (!issue && commit_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            ent_data[cdb_tag] <= cdb_data;
        end
        if (issue) begin
            ent_reg[issue_tag] <= issue_dest;
        end
    end

    // allocation only into a free slot or the one committing now
    a_alloc_free: assert property (@(posedge clk) disable iff (reset)
        issue |-> !ent_valid[issue_tag] || (commit_valid && issue_tag == rob_head));

    a_cdb_target: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> ent_valid[cdb_tag] && !ent_done[cdb_tag]);

endmodule

`default_nettype wire

//--- rtl/alu_station.sv
`timescale 1ns/1ps
`default_nettype none

module alu_station (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  ooo_pkg::alu_op_e  issue_op,
    input  ooo_pkg::rob_tag_t issue_tag,
    input  ooo_pkg::word_t    issue_v1,
    input  ooo_pkg::word_t    issue_v2,
    input  logic              issue_r1,
    input  logic              issue_r2,
    input  ooo_pkg::rob_tag_t issue_t1,
    input  ooo_pkg::rob_tag_t issue_t2,
    input  ooo_pkg::rob_tag_t rob_head,
    output logic              rs_full,
    output logic              cdb_valid,
    output ooo_pkg::rob_tag_t cdb_tag,
    output ooo_pkg::word_t    cdb_data
);
    import ooo_pkg::*;

    logic     ent_valid [RS_SIZE];
    alu_op_e  ent_op    [RS_SIZE];
    rob_tag_t ent_tag   [RS_SIZE];
    word_t    ent_v1    [RS_SIZE];
    word_t    ent_v2    [RS_SIZE];
    logic     ent_r1    [RS_SIZE];
    logic     ent_r2    [RS_SIZE];
    rob_tag_t ent_t1    [RS_SIZE];
    rob_tag_t ent_t2    [RS_SIZE];
    rob_tag_t ent_age   [RS_SIZE];

    logic                       sel_found;
    logic                       free_found;
    logic [$clog2(RS_SIZE)-1:0] sel_idx;
    logic [$clog2(RS_SIZE)-1:0] free_idx;
    rob_tag_t                   best_age;

    function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            ALU_SLT:  return word_t'($signed(a) < $signed(b));
            ALU_SLTU: return word_t'(a < b);
            default:  return a + b;
        endcase
    endfunction

    // oldest ready entry, age counted from the ROB head
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        best_age  = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            ent_age[i] = ent_tag[i] - rob_head;
            if (ent_valid[i] && ent_r1[i] && ent_r2[i] &&
                (!sel_found || ent_age[i] < best_age)) begin
                sel_found = 1'b1;
                sel_idx   = ($clog2(RS_SIZE))'(i);
                best_age  = ent_age[i];
            end
        end
    end

    // lowest free slot
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = ($clog2(RS_SIZE))'(i);
            end
        end
    end

    assign rs_full = !free_found;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                ent_valid[i] <= 1'b0;
            end
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= sel_found;
            if (sel_found) begin
                ent_valid[sel_idx] <= 1'b0;
            end
            if (issue) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // snoop the bus for waiting operands
        for (int i = 0; i < RS_SIZE; i++) begin
            if (cdb_valid && ent_valid[i] && !ent_r1[i] && ent_t1[i] == cdb_tag) begin
                ent_v1[i] <= cdb_data;
                ent_r1[i] <= 1'b1;
            end
            if (cdb_valid && ent_valid[i] && !ent_r2[i] && ent_t2[i] == cdb_tag) begin
                ent_v2[i] <= cdb_data;
                ent_r2[i] <= 1'b1;
            end
        end
        if (issue) begin
            ent_op[free_idx]  <= issue_op;
            ent_tag[free_idx] <= issue_tag;
            ent_v1[free_idx]  <= issue_v1;
            ent_v2[free_idx]  <= issue_v2;
            ent_r1[free_idx]  <= issue_r1;
            ent_r2[free_idx]  <= issue_r2;
            ent_t1[free_idx]  <= issue_t1;
            ent_t2[free_idx]  <= issue_t2;
        end
        cdb_tag  <= ent_tag[sel_idx];
        cdb_data <= alu(ent_op[sel_idx], ent_v1[sel_idx], ent_v2[sel_idx]);
    end

    // an issue always lands in an empty entry
    a_issue_free: assert property (@(posedge clk) disable iff (reset)
        issue |-> !ent_valid[free_idx]);

    a_cdb_once: assert property (@(posedge clk) disable iff (reset)
        cdb_valid && $past(cdb_valid) |-> cdb_tag != $past(cdb_tag));

endmodule

`default_nettype wire

//--- rtl/dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module dispatcher (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  ooo_pkg::alu_op_e   op,
    input  ooo_pkg::inst_fmt_e fmt,
    input  ooo_pkg::reg_addr_t rd,
    input  ooo_pkg::reg_addr_t rs1,
    input  ooo_pkg::reg_addr_t rs2,
    input  ooo_pkg::word_t     imm,
    input  logic               src1_busy,
    input  ooo_pkg::rob_tag_t  src1_tag,
    input  logic               src2_busy,
    input  ooo_pkg::rob_tag_t  src2_tag,
    input  ooo_pkg::word_t     rf_data1,
    input  ooo_pkg::word_t     rf_data2,
    input  logic               rob_ready1,
    input  ooo_pkg::word_t     rob_data1,
    input  logic               rob_ready2,
    input  ooo_pkg::word_t     rob_data2,
    input  logic               rob_full,
    input  ooo_pkg::rob_tag_t  rob_tail,
    input  logic               rs_full,
    input  logic               cdb_valid,
    input  ooo_pkg::rob_tag_t  cdb_tag,
    input  ooo_pkg::word_t     cdb_data,
    output ooo_pkg::reg_addr_t src1_reg,
    output ooo_pkg::reg_addr_t src2_reg,
    output logic               stall,
    output logic               issue,
    output ooo_pkg::alu_op_e   issue_op,
    output ooo_pkg::reg_addr_t issue_dest,
    output ooo_pkg::rob_tag_t  issue_tag,
    output ooo_pkg::word_t     issue_v1,
    output ooo_pkg::word_t     issue_v2,
    output logic               issue_r1,
    output logic               issue_r2,
    output ooo_pkg::rob_tag_t  issue_t1,
    output ooo_pkg::rob_tag_t  issue_t2,
    output logic               rename_valid,
    output ooo_pkg::reg_addr_t rename_reg,
    output ooo_pkg::rob_tag_t  rename_tag
);
    import ooo_pkg::*;

    logic      slot_valid;
    alu_op_e   slot_op;
    inst_fmt_e slot_fmt;
    reg_addr_t slot_rd;
    word_t     slot_imm;

    // ready bit on top of the operand value
    function automatic logic [XLEN:0] resolve(input logic busy, input rob_tag_t tag,
                                              input word_t rf_val, input logic rob_rdy,
                                              input word_t rob_val, input logic cdb_hit,
                                              input word_t cdb_val);
        src_stat_e stat;
        stat = !busy ? SRC_RF : (rob_rdy ? SRC_ROB : SRC_PEND);
        case (stat)
            SRC_RF:  return {1'b1, rf_val};
            SRC_ROB: return {1'b1, rob_val};
            default: return cdb_hit ? {1'b1, cdb_val} : {1'b0, tag, {(XLEN-3){1'b0}}};
        endcase
    endfunction

    assign issue = slot_valid && !rob_full && !rs_full;
    assign stall = slot_valid && !issue;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (!stall) begin
            slot_valid <= inst_valid;
        end
    end

    // held instruction, reloaded when empty or issuing
    always_ff @(posedge clk) begin
        if (!stall) begin
            slot_op  <= op;
            slot_fmt <= fmt;
            slot_rd  <= rd;
            src1_reg <= rs1;
            src2_reg <= rs2;
            slot_imm <= imm;
        end
    end

    assign {issue_r1, issue_v1} = resolve(src1_busy, src1_tag, rf_data1, rob_ready1,
                                          rob_data1, cdb_valid && cdb_tag == src1_tag,
                                          cdb_data);
    assign {issue_r2, issue_v2} = (slot_fmt == FMT_RI) ? {1'b1, slot_imm} :
                                  resolve(src2_busy, src2_tag, rf_data2, rob_ready2,
                                          rob_data2, cdb_valid && cdb_tag == src2_tag,
                                          cdb_data);

    assign issue_op   = slot_op;
    assign issue_dest = slot_rd;
    assign issue_tag  = rob_tail;
    assign issue_t1   = src1_tag;
    assign issue_t2   = src2_tag;

    assign rename_valid = issue && slot_rd != '0;
    assign rename_reg   = slot_rd;
    assign rename_tag   = rob_tail;

endmodule

`default_nettype wire

//--- rtl/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic               clk,
    input  logic               reset,
    input  logic               rename_valid,
    input  ooo_pkg::reg_addr_t rename_reg,
    input  ooo_pkg::rob_tag_t  rename_tag,
    input  ooo_pkg::reg_addr_t rs1,
    input  ooo_pkg::reg_addr_t rs2,
    input  logic               commit_valid,
    input  ooo_pkg::reg_addr_t commit_reg,
    input  ooo_pkg::rob_tag_t  commit_tag,
    output logic               src1_busy,
    output ooo_pkg::rob_tag_t  src1_tag,
    output logic               src2_busy,
    output ooo_pkg::rob_tag_t  src2_tag
);
    import ooo_pkg::*;

    logic     busy   [REG_NUM];
    rob_tag_t tag_of [REG_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                busy[i] <= 1'b0;
            end
        end else begin
            // only clear if no younger writer took the register over
            if (commit_valid && busy[commit_reg] && tag_of[commit_reg] == commit_tag) begin
                busy[commit_reg] <= 1'b0;
            end
            // new rename wins over a same-cycle commit
            if (rename_valid) begin
                busy[rename_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_valid) begin
            tag_of[rename_reg] <= rename_tag;
        end
    end

    assign src1_busy = busy[rs1];
    assign src1_tag  = tag_of[rs1];
    assign src2_busy = busy[rs2];
    assign src2_tag  = tag_of[rs2];

    // dispatcher must never rename x0
    a_x0_free: assert property (@(posedge clk) disable iff (reset) !busy[0]);

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  ooo_pkg::word_t     inst_word,
    output ooo_pkg::alu_op_e   op,
    output ooo_pkg::inst_fmt_e fmt,
    output ooo_pkg::reg_addr_t rd,
    output ooo_pkg::reg_addr_t rs1,
    output ooo_pkg::reg_addr_t rs2,
    output ooo_pkg::word_t     imm
);
    import ooo_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = inst_word[6:0];
    assign funct3 = inst_word[14:12];
    assign alt    = inst_word[30];

    always_comb begin
        // unsupported words become add x0, x0, x0
        op  = ALU_ADD;
        fmt = FMT_NONE;
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            fmt = (opcode == OPC_OP) ? FMT_RR : FMT_RI;
            rd  = inst_word[11:7];
            rs1 = inst_word[19:15];
            rs2 = (opcode == OPC_OP) ? inst_word[24:20] : '0;
            imm = {{(XLEN-12){inst_word[31]}}, inst_word[31:20]};
            case (funct3)
                3'b000: op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
                3'b001: op = ALU_SLL;
                3'b010: op = ALU_SLT;
                3'b011: op = ALU_SLTU;
                3'b100: op = ALU_XOR;
                3'b101: op = alt ? ALU_SRA : ALU_SRL;
                3'b110: op = ALU_OR;
                default: op = ALU_AND;
            endcase
            // shift immediates carry only the shamt field
            if (funct3 == 3'b001 || funct3 == 3'b101) begin
                imm = {{(XLEN-5){1'b0}}, inst_word[24:20]};
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN     = 32;
    localparam int REG_NUM  = 32;
    localparam int ROB_SIZE = 8;
    localparam int RS_SIZE  = 4;

    // RV32I major opcodes that the core executes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // where a source operand comes from at issue
    typedef enum logic [1:0] {
        SRC_RF,
        SRC_ROB,
        SRC_PEND
    } src_stat_e;

    typedef enum logic [1:0] {
        FMT_RR,
        FMT_RI,
        FMT_NONE
    } inst_fmt_e;

endpackage

`default_nettype wire
